/* verilog/fetch_params.svh */
//////////////////////////////////////////////////////////////////////
// widths, reset pc, nop encoding and instruction memory defaults
// for the fetch front end, included by the package and the RTL
//////////////////////////////////////////////////////////////////////

`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// datapath widths
`define FETCH_ADDR_W 32
`define FETCH_INSN_W 32

// first pc fetched after reset
`define FETCH_RESET_PC 32'h0000_0100

// nop is opcode 0x05 in the top six bits
`define FETCH_NOP_INSN ({6'h05, {(`FETCH_INSN_W - 6){1'b0}}})

// instruction memory defaults
`define ROM_DEPTH_LOG2_DEF 8
`define ROM_WAIT_DEF 1

`endif

/* verilog/fetch_pkg.sv */
//////////////////////////////////////////////////////////////////////
// shared types of the fetch front end: pc and instruction vectors,
// the fetch FSM states and the bus, redirect and decode structs
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "fetch_params.svh"

package fetch_pkg;

   typedef logic [`FETCH_ADDR_W-1:0] addr_t;
   typedef logic [`FETCH_INSN_W-1:0] insn_t;

   typedef enum logic [2:0] {
      s_init,
      s_du_restart,
      s_load_req,
      s_advance,
      s_stall,
      s_branch_waitbus,
      s_branch,
      s_branch_done
   } fetch_state_e;

   // instruction bus, request side
   typedef struct packed {
      addr_t adr;
      logic  req;
   } ibus_req_t;

   // instruction bus, response side
   typedef struct packed {
      logic  ack;
      logic  err;
      insn_t dat;
   } ibus_rsp_t;

   typedef struct packed {
      logic  branch_occur;
      addr_t branch_dest;
      logic  du_restart;
      addr_t du_restart_pc;
      logic  flush;
   } redirect_t;

   typedef struct packed {
      addr_t pc;
      insn_t insn;
      logic  valid;
      logic  ibus_err;
      logic  branch_taken;
   } decode_t;

endpackage

`default_nettype wire

/* verilog/insn_rom.sv */
//////////////////////////////////////////////////////////////////////
// instruction memory slave on the fetch bus; answers each access
// after a fixed number of wait states, err outside its depth;
// filled through the preload port while the core is held in reset
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module insn_rom
   import fetch_pkg::*;
#(
   parameter int DEPTH_LOG2  = `ROM_DEPTH_LOG2_DEF,
   parameter int WAIT_STATES = `ROM_WAIT_DEF
) (
   input  logic      clk,
   input  logic      rst,
   input  ibus_req_t ibus_i,
   output ibus_rsp_t ibus_o,
   input  logic      load_we_i,
   input  addr_t     load_addr_i,
   input  insn_t     load_data_i
);

   localparam int DEPTH = 1 << DEPTH_LOG2;
   localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

   insn_t                 mem [DEPTH];
   logic [CNT_W-1:0]      cnt_q;
   logic [CNT_W-1:0]      cur_cnt;
   addr_t                 adr_q;
   logic [DEPTH_LOG2-1:0] rd_idx;
   logic [DEPTH_LOG2-1:0] wr_idx;
   logic                  in_range;
   logic                  done;

   // word addressed, byte offset ignored
   assign rd_idx   = ibus_i.adr[DEPTH_LOG2+1:2];
   assign wr_idx   = load_addr_i[DEPTH_LOG2+1:2];
   assign in_range = (ibus_i.adr >> (DEPTH_LOG2 + 2)) == '0;

   // a changed address starts a fresh access
   assign cur_cnt = (ibus_i.adr == adr_q) ? cnt_q : '0;
   assign done    = ibus_i.req & (cur_cnt == CNT_W'(WAIT_STATES));

   assign ibus_o.ack = done & in_range;
   assign ibus_o.err = done & ~in_range;
   assign ibus_o.dat = mem[rd_idx];

   always_ff @(posedge clk) begin
      if (rst || !ibus_i.req || done) begin
         cnt_q <= '0;
      end else begin
         cnt_q <= cur_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      adr_q <= ibus_i.adr;
   end

   always_ff @(posedge clk) begin
      if (load_we_i) begin
         mem[wr_idx] <= load_data_i;
      end
   end

endmodule

`default_nettype wire

/* verilog/fetch_unit.sv */
//////////////////////////////////////////////////////////////////////
// instruction fetch unit: requests words on the instruction bus and
// hands pc and instruction to decode with a valid strobe; reacts to
// pipeline advance, branches, debug restarts, flushes and bus errors
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module fetch_unit
   import fetch_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   output ibus_req_t ibus_o,
   input  ibus_rsp_t ibus_i,
   input  logic      padv_i,
   input  redirect_t redirect_i,
   output decode_t   decode_o
);

   fetch_state_e state;
   fetch_state_e pre_stall_state;

   // pc_addr is on the bus, pc_fetch is the pc saved on a stall
   addr_t pc_addr;
   addr_t pc_fetch;
   addr_t pc_addr_next;

   logic  req_q;
   logic  valid_q;
   logic  branch_taken_q;
   logic  ibus_err_q;
   logic  branch_fetch_valid;
   logic  branch_occur_r;

   addr_t dec_pc_q;
   insn_t dec_insn_q;

   logic  bus_done;
   logic  branch_edge;
   logic  new_branch;
   logic  fetching;
   logic  stall_entry;
   logic  capture;
   logic  target_ok;

   assign bus_done     = ibus_i.ack | ibus_i.err;
   assign pc_addr_next = pc_addr + addr_t'(4);
   assign branch_edge  = redirect_i.branch_occur & ~branch_occur_r;

   // in advance the level is new; after a branch only a fresh edge counts
   assign new_branch = redirect_i.branch_occur & ((state == s_advance) | branch_edge);

   assign fetching = (state == s_advance) | (state == s_branch_waitbus) |
                     (state == s_branch) | (state == s_branch_done);

   assign stall_entry = ~padv_i & fetching;
   assign capture     = bus_done & padv_i & fetching;

   // first word at the branch target came back clean
   assign target_ok = (state == s_branch) & ibus_i.ack & padv_i & ~branch_edge;

   assign ibus_o.adr = pc_addr;
   assign ibus_o.req = req_q;

   assign decode_o.pc           = dec_pc_q;
   assign decode_o.insn         = dec_insn_q;
   assign decode_o.valid        = valid_q;
   assign decode_o.ibus_err     = ibus_err_q;
   assign decode_o.branch_taken = branch_taken_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         branch_occur_r <= 1'b0;
      end else begin
         branch_occur_r <= redirect_i.branch_occur;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state              <= s_init;
         pre_stall_state    <= s_advance;
         pc_addr            <= `FETCH_RESET_PC;
         pc_fetch           <= `FETCH_RESET_PC;
         req_q              <= 1'b0;
         valid_q            <= 1'b0;
         branch_taken_q     <= 1'b0;
         branch_fetch_valid <= 1'b0;
      end else begin
         // strobes by default
         valid_q        <= 1'b0;
         branch_taken_q <= 1'b0;

         case (state)
            s_init: begin
               req_q <= 1'b1;
               state <= s_load_req;
            end

            s_du_restart: begin
               // let anything still answering drain first
               if (!bus_done) begin
                  req_q <= 1'b1;
                  state <= s_load_req;
               end
            end

            s_load_req: begin
               state <= pre_stall_state;
            end

            s_advance, s_branch_done: begin
               if (new_branch) begin
                  if (bus_done) begin
                     // delay slot only if nothing went out last cycle
                     valid_q <= ~valid_q;
                     pc_addr <= redirect_i.branch_dest;
                     state   <= s_branch;
                  end else begin
                     branch_fetch_valid <= ~valid_q;
                     state              <= s_branch_waitbus;
                  end
               end else begin
                  if (bus_done) begin
                     valid_q <= 1'b1;
                     pc_addr <= pc_addr_next;
                  end
                  if ((state == s_branch_done) && !redirect_i.branch_occur) begin
                     state <= s_advance;
                  end
               end
            end

            s_branch_waitbus: begin
               if (bus_done) begin
                  valid_q <= branch_fetch_valid;
                  pc_addr <= redirect_i.branch_dest;
                  state   <= s_branch;
               end
            end

            s_branch: begin
               // another branch while this one is still fetching
               if (branch_edge) begin
                  if (bus_done) begin
                     pc_addr <= redirect_i.branch_dest;
                  end else begin
                     branch_fetch_valid <= 1'b0;
                     state              <= s_branch_waitbus;
                  end
               end else if (bus_done) begin
                  valid_q        <= 1'b1;
                  branch_taken_q <= 1'b1;
                  pc_addr        <= pc_addr_next;
                  state          <= s_branch_done;
               end
            end

            s_stall: begin
               if (!padv_i) begin
                  valid_q <= valid_q;
               end
               if (req_q) begin
                  if (bus_done) begin
                     req_q <= 1'b0;
                  end
               end else if (padv_i) begin
                  pc_addr <= pc_fetch;
                  req_q   <= 1'b1;
                  state   <= s_load_req;
               end
            end

            default: begin
               state <= s_init;
            end
         endcase

         // padv low freezes the pipe, the access in flight is refetched later
         if (stall_entry) begin
            if (bus_done) begin
               req_q <= 1'b0;
            end
            pc_addr         <= pc_addr;
            pc_fetch        <= pc_addr;
            valid_q         <= valid_q;
            branch_taken_q  <= 1'b0;
            pre_stall_state <= state;
            state           <= s_stall;
         end

         // debug restart wins over everything
         if (redirect_i.du_restart) begin
            pc_addr         <= redirect_i.du_restart_pc;
            req_q           <= 1'b0;
            valid_q         <= 1'b0;
            branch_taken_q  <= 1'b0;
            pre_stall_state <= s_advance;
            state           <= s_du_restart;
         end

         if (redirect_i.flush) begin
            valid_q <= 1'b0;
         end
      end
   end

   // word and pc to decode, nop in place of a faulting fetch
   always_ff @(posedge clk) begin
      if (capture) begin
         dec_pc_q   <= pc_addr;
         dec_insn_q <= ibus_i.err ? insn_t'(`FETCH_NOP_INSN) : ibus_i.dat;
      end
   end

   // sticky until a restart or a clean branch target
   always_ff @(posedge clk) begin
      if (rst || redirect_i.du_restart) begin
         ibus_err_q <= 1'b0;
      end else if (capture && ibus_i.err) begin
         ibus_err_q <= 1'b1;
      end else if (target_ok) begin
         ibus_err_q <= 1'b0;
      end
   end

endmodule

`default_nettype wire

/* verilog/fetch_top.sv */
//////////////////////////////////////////////////////////////////////
// fetch front end: fetch unit on the instruction memory, with the
// redirect, preload and decode ports brought out and the bus
// request visible for monitoring
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module fetch_top
   import fetch_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  logic      padv_i,
   input  redirect_t redirect_i,
   input  logic      load_we_i,
   input  addr_t     load_addr_i,
   input  insn_t     load_data_i,
   output decode_t   decode_o,
   output ibus_req_t ibus_req_o
);

   ibus_rsp_t ibus_rsp;

   fetch_unit i_fetch_unit (
      .clk        (clk),
      .rst        (rst),
      .ibus_o     (ibus_req_o),
      .ibus_i     (ibus_rsp),
      .padv_i     (padv_i),
      .redirect_i (redirect_i),
      .decode_o   (decode_o)
   );

   insn_rom #(
      .DEPTH_LOG2  (`ROM_DEPTH_LOG2_DEF),
      .WAIT_STATES (`ROM_WAIT_DEF)
   ) i_insn_rom (
      .clk         (clk),
      .rst         (rst),
      .ibus_i      (ibus_req_o),
      .ibus_o      (ibus_rsp),
      .load_we_i   (load_we_i),
      .load_addr_i (load_addr_i),
      .load_data_i (load_data_i)
   );

endmodule

`default_nettype wire

/* tests/tb_fetch_top.sv */
//////////////////////////////////////////////////////////////////////
// testbench for the fetch front end; fills the instruction memory,
// runs the steps of tests/fetch_cases.txt and checks every delivered
// pc, word and flag against a model of the expected stream
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module tb_fetch_top
   import fetch_pkg::*;
();

   localparam int rom_words  = 1 << `ROM_DEPTH_LOG2_DEF;
   localparam int wait_limit = 64;

   logic      clk = 1'b0;
   logic      rst;
   logic      padv;
   redirect_t redir;
   logic      load_we;
   addr_t     load_addr;
   insn_t     load_data;
   decode_t   dec;
   ibus_req_t ibus_req;

   insn_t mem_copy [rom_words];
   int    seed = 73004;
   int    errors = 0;
   int    steps_ok = 0;
   int    steps_bad = 0;
   logic  timed_out = 1'b0;

   // expected stream state
   addr_t model_pc = `FETCH_RESET_PC;
   logic  err_exp = 1'b0;

   fetch_top i_fetch_top (
      .clk         (clk),
      .rst         (rst),
      .padv_i      (padv),
      .redirect_i  (redir),
      .load_we_i   (load_we),
      .load_addr_i (load_addr),
      .load_data_i (load_data),
      .decode_o    (dec),
      .ibus_req_o  (ibus_req)
   );

   always #20 clk = ~clk;

   task automatic check_addr(input string name, input addr_t exp, input addr_t act);
      if (exp !== act) begin
         $display("** Error %s: expected pc %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_insn(input string name, input insn_t exp, input insn_t act);
      if (exp !== act) begin
         $display("** Error %s: expected insn %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         $display("** Error %s: expected %b, actual %b", name, exp, act);
         errors++;
      end
   endtask

   // word index below the memory depth
   function automatic logic in_depth(input addr_t pc);
      return (pc >> 2) < addr_t'(rom_words);
   endfunction

   function automatic insn_t expected_word(input addr_t pc);
      if (in_depth(pc)) begin
         return mem_copy[pc[`ROM_DEPTH_LOG2_DEF+1:2]];
      end
      return `FETCH_NOP_INSN;
   endfunction

   task automatic check_delivery(input string name, input logic taken);
      if (!in_depth(model_pc)) begin
         err_exp = 1'b1;
      end else if (taken) begin
         err_exp = 1'b0;
      end
      check_addr(name, model_pc, dec.pc);
      check_insn(name, expected_word(model_pc), dec.insn);
      check_flag({name, " ibus_err"}, err_exp, dec.ibus_err);
      check_flag({name, " branch_taken"}, taken, dec.branch_taken);
      model_pc = model_pc + addr_t'(4);
   endtask

   task automatic wait_valid(input string name, output logic got);
      int n;
      n = 0;
      got = 1'b0;
      while (!got && n < wait_limit) begin
         @(negedge clk);
         got = dec.valid;
         n++;
      end
      if (!got) begin
         $display("%s: no valid strobe within %0d cycles", name, wait_limit);
         errors++;
         timed_out = 1'b1;
      end
   endtask

   task automatic sync_to_valid(input string name);
      logic got;
      wait_valid(name, got);
      if (got) begin
         check_delivery(name, 1'b0);
      end
   endtask

   // checks the first delivery after a redirect and its pc when exp_pc is nonzero
   task automatic first_after(input string name, input addr_t exp_pc);
      logic got;
      wait_valid(name, got);
      if (got) begin
         if (exp_pc != '0) begin
            check_addr(name, exp_pc, dec.pc);
         end
         check_delivery(name, 1'b0);
      end
   endtask

   task automatic run_cycles(input string name, input addr_t n);
      repeat (int'(n)) begin
         @(negedge clk);
         if (dec.valid) begin
            check_delivery(name, 1'b0);
         end
      end
   endtask

   task automatic take_branch(input string name, input addr_t dest, input addr_t exp_pc,
                              input logic to_error);
      logic got;
      logic done;
      int   slots;
      done = 1'b0;
      slots = 0;
      sync_to_valid(name);
      if (timed_out) return;
      @(posedge clk);
      redir.branch_occur <= 1'b1;
      redir.branch_dest  <= dest;
      @(posedge clk);
      redir.branch_occur <= 1'b0;
      while (!done && !timed_out) begin
         wait_valid(name, got);
         if (got && dec.branch_taken) begin
            model_pc = dest;
            check_addr(name, exp_pc, dec.pc);
            check_delivery(name, 1'b1);
            done = 1'b1;
         end else if (got) begin
            // an old-stream instruction here can only be the delay slot
            slots++;
            check_delivery(name, 1'b0);
            if (slots > 1) begin
               $display("%s: more than one old-stream instruction after the branch", name);
               errors++;
               done = 1'b1;
            end
         end
      end
      if (timed_out) return;
      @(negedge clk);
      check_flag({name, " taken pulse"}, 1'b0, dec.branch_taken);
      if (to_error) begin
         check_flag({name, " ibus_err"}, 1'b1, dec.ibus_err);
         check_insn(name, `FETCH_NOP_INSN, dec.insn);
      end
   endtask

   task automatic stall_pipe(input string name, input addr_t n, input addr_t exp_pc);
      addr_t hold_pc;
      insn_t hold_insn;
      sync_to_valid(name);
      if (timed_out) return;
      hold_pc = dec.pc;
      hold_insn = dec.insn;
      @(posedge clk);
      padv <= 1'b0;
      repeat (int'(n)) begin
         @(negedge clk);
         check_addr({name, " hold"}, hold_pc, dec.pc);
         check_insn({name, " hold"}, hold_insn, dec.insn);
         check_flag({name, " valid"}, 1'b0, dec.valid);
      end
      @(posedge clk);
      padv <= 1'b1;
      first_after(name, exp_pc);
   endtask

   task automatic debug_restart(input string name, input addr_t pc, input addr_t exp_pc);
      sync_to_valid(name);
      if (timed_out) return;
      @(posedge clk);
      redir.du_restart    <= 1'b1;
      redir.du_restart_pc <= pc;
      @(posedge clk);
      redir.du_restart <= 1'b0;
      model_pc = pc;
      err_exp = 1'b0;
      first_after(name, exp_pc);
   endtask

   task automatic flush_pipe(input string name, input addr_t exp_pc);
      sync_to_valid(name);
      if (timed_out) return;
      @(posedge clk);
      redir.flush <= 1'b1;
      @(posedge clk);
      redir.flush <= 1'b0;
      @(negedge clk);
      check_flag({name, " valid"}, 1'b0, dec.valid);
      // the access completing under the flush is squashed
      model_pc = model_pc + addr_t'(4);
      first_after(name, exp_pc);
   endtask

   task automatic report_step(input string name, input int start);
      if (errors == start) begin
         steps_ok++;
         $display("%s: ok", name);
      end else begin
         steps_bad++;
         $display("%s: FAILED with %0d errors", name, errors - start);
      end
   endtask

   task automatic execute_step(input string name, input string op, input addr_t arg,
                               input addr_t exp_pc);
      int start;
      start = errors;
      if (op == "r") begin
         run_cycles(name, arg);
      end else if (op == "b") begin
         take_branch(name, arg, exp_pc, 1'b0);
      end else if (op == "j") begin
         take_branch(name, arg, exp_pc, 1'b1);
      end else if (op == "s") begin
         stall_pipe(name, arg, exp_pc);
      end else if (op == "d") begin
         debug_restart(name, arg, exp_pc);
      end else if (op == "f") begin
         flush_pipe(name, exp_pc);
      end else begin
         $display("%s: unknown operation %s in the case file", name, op);
         errors++;
      end
      report_step(name, start);
   endtask

   initial begin
      int    fd;
      int    rc;
      int    nf;
      int    start;
      string line;
      string name;
      string op;
      addr_t arg;
      addr_t exp_pc;
      insn_t word;

      rst       <= 1'b1;
      padv      <= 1'b1;
      redir     <= '0;
      load_we   <= 1'b0;
      load_addr <= '0;
      load_data <= '0;

      // fill the memory under reset and hold reset eight cycles more
      for (int i = 0; i < rom_words; i++) begin
         @(posedge clk);
         word = $random(seed);
         mem_copy[i] = word;
         load_we   <= 1'b1;
         load_addr <= addr_t'(i * 4);
         load_data <= word;
      end
      @(posedge clk);
      load_we <= 1'b0;
      repeat (8) @(posedge clk);
      rst <= 1'b0;

      start = errors;
      @(negedge clk);
      check_flag("reset req", 1'b0, ibus_req.req);
      check_flag("reset valid", 1'b0, dec.valid);
      check_flag("reset branch_taken", 1'b0, dec.branch_taken);
      check_flag("reset ibus_err", 1'b0, dec.ibus_err);
      // request goes out in the second cycle at the reset pc
      @(negedge clk);
      check_flag("reset req rise", 1'b1, ibus_req.req);
      check_addr("reset adr", `FETCH_RESET_PC, ibus_req.adr);
      report_step("reset_state", start);

      fd = $fopen("tests/fetch_cases.txt", "r");
      if (fd == 0) begin
         $display("case file tests/fetch_cases.txt could not be opened");
         errors++;
      end else begin
         while (!$feof(fd) && !timed_out) begin
            line = "";
            rc = $fgets(line, fd);
            if (rc > 0 && line.getc(0) != "#") begin
               nf = $sscanf(line, "%s %s %h %h", name, op, arg, exp_pc);
               if (nf == 4) begin
                  execute_step(name, op, arg, exp_pc);
               end
            end
         end
         $fclose(fd);
      end

      $display("steps passed %0d, steps failed %0d", steps_ok, steps_bad);
      if (errors == 0 && !timed_out) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tests/fetch_cases.txt */
# name, op (r run, b branch, s stall, d debug restart, f flush, j jump out of range)
# arg is cycles or target pc, exp is the first pc after the step or 0; numbers in hex
reset_run    r 40   0
stall_a      s 8    0
branch_a     b 200  200
flush_a      f 0    20c
run_b        r 20   0
restart_a    d 180  180
stall_b      s 10   188
run_c        r 18   0
jump_err     j 2000 2000
run_err      r 10   0
branch_back  b 300  300
run_d        r 10   0
branch_end   b 3f0  3f0
run_edge     r 20   0
restart_b    d 100  100
run_f        r 10   0

/* filelist.f */
+incdir+verilog
verilog/fetch_pkg.sv
verilog/insn_rom.sv
verilog/fetch_unit.sv
verilog/fetch_top.sv
tests/tb_fetch_top.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal --Mdir obj_dir
TOP       = tb_fetch_top
FILELIST  = filelist.f
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
